//--- fpClassify.sv
// Splits one single-precision word into sign, exponent, significand and FCLASS bits
`timescale 1ns/1ps
`default_nettype none

module fpClassify (
        input  fpuPkg::fpWord_t word_i,
        fpOperandIf.source      opnd
);
        import fpuPkg::*;

        logic                  sign;
        fpExp_t                exp;
        logic [SIG_LEN-1:0]    frac;
        logic                  expZero;
        logic                  expOnes;
        logic                  fracZero;
        logic                  isNormal;

        assign sign     = word_i[FLEN-1];
        assign exp      = word_i[FLEN-2:SIG_LEN];
        assign frac     = word_i[SIG_LEN-1:0];

        assign expZero  = (exp == '0);
        assign expOnes  = (exp == '1);
        assign fracZero = (frac == '0);
        assign isNormal = !expZero && !expOnes;

        assign opnd.sign = sign;
        assign opnd.exp  = exp;
        // Hidden bit only for normals, subnormals keep a leading zero
        assign opnd.sig  = {isNormal, frac};

        always_comb begin
                opnd.cls = '0;
                if (expOnes) begin
                        if (fracZero) begin
                                if (sign)
                                        opnd.cls[CLS_NEG_INF] = 1'b1;
                                else
                                        opnd.cls[CLS_POS_INF] = 1'b1;
                        end else if (frac[SIG_LEN-1]) begin
                                opnd.cls[CLS_QNAN] = 1'b1;
                        end else begin
                                opnd.cls[CLS_SNAN] = 1'b1;
                        end
                end else if (expZero) begin
                        if (fracZero) begin
                                if (sign)
                                        opnd.cls[CLS_NEG_ZERO] = 1'b1;
                                else
                                        opnd.cls[CLS_POS_ZERO] = 1'b1;
                        end else begin
                                if (sign)
                                        opnd.cls[CLS_NEG_SUB] = 1'b1;
                                else
                                        opnd.cls[CLS_POS_SUB] = 1'b1;
                        end
                end else begin
                        if (sign)
                                opnd.cls[CLS_NEG_NORM] = 1'b1;
                        else
                                opnd.cls[CLS_POS_NORM] = 1'b1;
                end
        end

        // Every known word lands in exactly one class, checked on each operand change
        clsOneHot: assert property (@(word_i)
                !$isunknown(word_i) |-> $onehot(opnd.cls))
                else $error("operand class is not one-hot");

endmodule

`default_nettype wire

//--- fpCompare.sv
// Ordering of two operands for FEQ/FLT/FLE and the FMIN/FMAX selection
`timescale 1ns/1ps
`default_nettype none

module fpCompare (
        fpOperandIf.sink         a,
        fpOperandIf.sink         b,
        input  fpuPkg::fpWord_t  rs1_i,
        input  fpuPkg::fpWord_t  rs2_i,
        input  fpuPkg::fpuOp_e   op_i,
        output logic             eq_o,
        output logic             lt_o,
        output logic             le_o,
        output fpuPkg::fpWord_t  minMax_o
);
        import fpuPkg::*;

        logic aNan;
        logic bNan;
        logic anyNan;
        logic bothZero;
        logic magLt;
        logic magEq;
        logic totalLt;
        logic ordLt;
        logic ordEq;
        logic isMax;

        assign aNan     = a.cls[CLS_SNAN] | a.cls[CLS_QNAN];
        assign bNan     = b.cls[CLS_SNAN] | b.cls[CLS_QNAN];
        assign anyNan   = aNan | bNan;
        assign bothZero = (a.cls[CLS_NEG_ZERO] | a.cls[CLS_POS_ZERO]) &
                          (b.cls[CLS_NEG_ZERO] | b.cls[CLS_POS_ZERO]);

        // Exponent first, then significand
        assign magLt = {a.exp, a.sig} <  {b.exp, b.sig};
        assign magEq = {a.exp, a.sig} == {b.exp, b.sig};

        // -0 sorts below +0 here
        always_comb begin
                if (a.sign != b.sign)
                        totalLt = a.sign;
                else if (!a.sign)
                        totalLt = magLt;
                else
                        totalLt = !magLt && !magEq;
        end

        // IEEE ordering treats the two zeros as equal
        assign ordLt = totalLt && !bothZero;
        assign ordEq = bothZero || (a.sign == b.sign && magEq);

        assign eq_o = !anyNan && ordEq;
        assign lt_o = !anyNan && ordLt;
        assign le_o = !anyNan && (ordLt || ordEq);

        assign isMax = (op_i == OP_MAX);

        always_comb begin
                if (aNan && bNan)
                        minMax_o = CANONICAL_NAN;
                else if (aNan)
                        minMax_o = rs2_i;
                else if (bNan)
                        minMax_o = rs1_i;
                else
                        minMax_o = (totalLt ^ isMax) ? rs1_i : rs2_i;
        end

endmodule

`default_nettype wire

//--- fpOperandIf.sv
// Decoded operand bundle, driven by a classifier and read by the compare and result blocks
`timescale 1ns/1ps
`default_nettype none

interface fpOperandIf;
        import fpuPkg::*;

        logic     sign;
        fpExp_t   exp;
        fpSig_t   sig;
        fpClass_t cls;

        modport source (
                output sign,
                output exp,
                output sig,
                output cls
        );

        modport sink (
                input sign,
                input exp,
                input sig,
                input cls
        );

endinterface

`default_nettype wire

//--- fpu.sv
// Single-precision FPU top level for sign injection, min/max, compare, classify and moves
`timescale 1ns/1ps
`default_nettype none

module fpu (
        input  logic               clk_i,
        input  logic               rstN_i,

        input  logic               fpuEnable_i,
        input  fpuPkg::fpWord_t    instr_i,
        input  fpuPkg::fpWord_t    rs1_i,
        input  fpuPkg::fpWord_t    rs2_i,

        output logic               valid_o,
        output fpuPkg::fpResult_t  fpuOut_o
);
        import fpuPkg::*;

        fpuOp_e  op;
        logic    eq;
        logic    lt;
        logic    le;
        fpWord_t minMax;

        fpOperandIf opA ();
        fpOperandIf opB ();

        fpuDecode decode (
                .instr_i (instr_i),
                .op_o    (op)
        );

        // One classifier per source register
        fpClassify classA (
                .word_i (rs1_i),
                .opnd   (opA)
        );

        fpClassify classB (
                .word_i (rs2_i),
                .opnd   (opB)
        );

        fpCompare compare (
                .a        (opA),
                .b        (opB),
                .rs1_i    (rs1_i),
                .rs2_i    (rs2_i),
                .op_i     (op),
                .eq_o     (eq),
                .lt_o     (lt),
                .le_o     (le),
                .minMax_o (minMax)
        );

        fpuResult result (
                .clk_i       (clk_i),
                .rstN_i      (rstN_i),
                .fpuEnable_i (fpuEnable_i),
                .op_i        (op),
                .rs1_i       (rs1_i),
                .rs2_i       (rs2_i),
                .cls         (opA),
                .eq_i        (eq),
                .lt_i        (lt),
                .le_i        (le),
                .minMax_i    (minMax),
                .valid_o     (valid_o),
                .result_o    (fpuOut_o)
        );

endmodule

`default_nettype wire

//--- fpuDecode.sv
// Instruction decoder, maps an OP-FP word to one operation code or OP_NONE
`timescale 1ns/1ps
`default_nettype none

module fpuDecode (
        input  fpuPkg::fpWord_t instr_i,
        output fpuPkg::fpuOp_e  op_o
);
        import fpuPkg::*;

        logic [6:0] opcode;
        logic [4:0] funct5;
        logic [2:0] funct3;
        logic [4:0] rs2Field;
        logic       isSingle;

        assign opcode   = instr_i[6:0];
        assign funct5   = instr_i[31:27];
        assign funct3   = instr_i[14:12];
        assign rs2Field = instr_i[24:20];

        // Only fmt == S under the plain OP-FP opcode, FMA opcodes never match
        assign isSingle = (opcode == OPCODE_OP_FP) &&
                          !instr_i[FMT_BIT] && !instr_i[FMT_BIT+1];

        always_comb begin
                op_o = OP_NONE;
                if (isSingle) begin
                        case (funct5)
                                FUNCT5_SGNJ: begin
                                        case (funct3)
                                                3'b000:  op_o = OP_SGNJ;
                                                3'b001:  op_o = OP_SGNJN;
                                                3'b010:  op_o = OP_SGNJX;
                                                default: op_o = OP_NONE;
                                        endcase
                                end
                                FUNCT5_MINMAX: begin
                                        case (funct3)
                                                3'b000:  op_o = OP_MIN;
                                                3'b001:  op_o = OP_MAX;
                                                default: op_o = OP_NONE;
                                        endcase
                                end
                                FUNCT5_CMP: begin
                                        case (funct3)
                                                3'b010:  op_o = OP_EQ;
                                                3'b001:  op_o = OP_LT;
                                                3'b000:  op_o = OP_LE;
                                                default: op_o = OP_NONE;
                                        endcase
                                end
                                FUNCT5_CLASS_MVXW: begin
                                        // rs2 field must be zero for both
                                        if (rs2Field == 5'd0) begin
                                                if (funct3 == 3'b001)
                                                        op_o = OP_CLASS;
                                                else if (funct3 == 3'b000)
                                                        op_o = OP_MVXW;
                                        end
                                end
                                FUNCT5_MVWX: begin
                                        if (rs2Field == 5'd0 && funct3 == 3'b000)
                                                op_o = OP_MVWX;
                                end
                                default: op_o = OP_NONE;
                        endcase
                end
        end

endmodule

`default_nettype wire

//--- fpuPkg.sv
// Shared widths, field types, class bits and operation codes, imported by every FPU block
`default_nettype none

package fpuPkg;

        // Format widths
        localparam int FLEN     = 32;
        localparam int XLEN_OUT = 64;
        localparam int EXP_LEN  = 8;
        localparam int SIG_LEN  = 23;

        typedef logic [FLEN-1:0]     fpWord_t;
        typedef logic [XLEN_OUT-1:0] fpResult_t;
        typedef logic [EXP_LEN-1:0]  fpExp_t;
        // Stored fraction plus the hidden bit
        typedef logic [SIG_LEN:0]    fpSig_t;
        typedef logic [9:0]          fpClass_t;

        // FCLASS bit order
        localparam int CLS_NEG_INF  = 0;
        localparam int CLS_NEG_NORM = 1;
        localparam int CLS_NEG_SUB  = 2;
        localparam int CLS_NEG_ZERO = 3;
        localparam int CLS_POS_ZERO = 4;
        localparam int CLS_POS_SUB  = 5;
        localparam int CLS_POS_NORM = 6;
        localparam int CLS_POS_INF  = 7;
        localparam int CLS_SNAN     = 8;
        localparam int CLS_QNAN     = 9;

        localparam fpWord_t CANONICAL_NAN = 32'h7fc0_0000;

        // funct5 field, bits 31:27
        localparam logic [4:0] FUNCT5_SGNJ       = 5'b00100;
        localparam logic [4:0] FUNCT5_MINMAX     = 5'b00101;
        localparam logic [4:0] FUNCT5_CMP        = 5'b10100;
        localparam logic [4:0] FUNCT5_CLASS_MVXW = 5'b11100;
        localparam logic [4:0] FUNCT5_MVWX       = 5'b11110;

        // Low bit of the fmt field, set for double
        localparam int FMT_BIT = 25;

        localparam logic [6:0] OPCODE_OP_FP = 7'b1010011;

        typedef enum logic [3:0] {
                OP_NONE,
                OP_SGNJ,
                OP_SGNJN,
                OP_SGNJX,
                OP_MIN,
                OP_MAX,
                OP_EQ,
                OP_LT,
                OP_LE,
                OP_CLASS,
                OP_MVXW,
                OP_MVWX
        } fpuOp_e;

endpackage

`default_nettype wire

//--- fpuResult.sv
// Result mux with sign injection and NaN boxing, registered on each enable strobe
`timescale 1ns/1ps
`default_nettype none

module fpuResult (
        input  logic               clk_i,
        input  logic               rstN_i,
        input  logic               fpuEnable_i,
        input  fpuPkg::fpuOp_e     op_i,
        input  fpuPkg::fpWord_t    rs1_i,
        input  fpuPkg::fpWord_t    rs2_i,
        fpOperandIf.sink           cls,
        input  logic               eq_i,
        input  logic               lt_i,
        input  logic               le_i,
        input  fpuPkg::fpWord_t    minMax_i,
        output logic               valid_o,
        output fpuPkg::fpResult_t  result_o
);
        import fpuPkg::*;

        fpWord_t   sgnjWord;
        fpWord_t   sgnjnWord;
        fpWord_t   sgnjxWord;
        fpResult_t nextResult;

        // Upper half all ones marks a valid single in a 64-bit register
        function automatic fpResult_t boxWord(input fpWord_t w);
                return {{(XLEN_OUT-FLEN){1'b1}}, w};
        endfunction

        // Magnitude from rs1, sign from rs2
        assign sgnjWord  = {rs2_i[FLEN-1], rs1_i[FLEN-2:0]};
        assign sgnjnWord = {~rs2_i[FLEN-1], rs1_i[FLEN-2:0]};
        assign sgnjxWord = {rs1_i[FLEN-1] ^ rs2_i[FLEN-1], rs1_i[FLEN-2:0]};

        always_comb begin
                case (op_i)
                        OP_SGNJ:          nextResult = boxWord(sgnjWord);
                        OP_SGNJN:         nextResult = boxWord(sgnjnWord);
                        OP_SGNJX:         nextResult = boxWord(sgnjxWord);
                        OP_MIN, OP_MAX:   nextResult = boxWord(minMax_i);
                        // Compare and classify go out zero-extended
                        OP_EQ:            nextResult = fpResult_t'(eq_i);
                        OP_LT:            nextResult = fpResult_t'(lt_i);
                        OP_LE:            nextResult = fpResult_t'(le_i);
                        OP_CLASS:         nextResult = fpResult_t'(cls.cls);
                        OP_MVXW, OP_MVWX: nextResult = boxWord(rs1_i);
                        default:          nextResult = '0;
                endcase
        end

        always_ff @(posedge clk_i or negedge rstN_i) begin
                if (!rstN_i) begin
                        valid_o  <= 1'b0;
                        result_o <= '0;
                end else begin
                        valid_o <= fpuEnable_i;
                        // Holds until the next strobe
                        if (fpuEnable_i)
                                result_o <= nextResult;
                end
        end

        // A lone strobe gives a single-cycle valid
        validSinglePulse: assert property (@(posedge clk_i) disable iff (!rstN_i)
                fpuEnable_i ##1 !fpuEnable_i |=> !valid_o)
                else $error("valid held after an idle enable");

        validKnown: assert property (@(posedge clk_i) disable iff (!rstN_i)
                !$isunknown(valid_o))
                else $error("valid is unknown out of reset");

endmodule

`default_nettype wire

//--- tb.f
fpuPkg.sv
fpOperandIf.sv
fpuDecode.sv
fpClassify.sv
fpCompare.sv
fpuResult.sv
fpu.sv
tbFpu.sv

//--- tbFpu.sv
// Directed testbench for the FPU top level, compiled from tb.f with tbFpu as top module
`timescale 1ns/1ps
`default_nettype none

module tbFpu;
        import fpuPkg::*;

        localparam int CLK_PERIOD   = 8;
        localparam int RESET_CYCLES = 16;
        localparam int RAND_PAIRS   = 8;
        localparam int NUM_CORNERS  = 10;
        // Enables issued over all tests
        localparam int NUM_OPS = 3 + RAND_PAIRS * 3 +
                                 NUM_CORNERS * NUM_CORNERS * 3 + RAND_PAIRS * 3 +
                                 NUM_CORNERS * NUM_CORNERS * 2 + RAND_PAIRS * 2 +
                                 NUM_CORNERS + 5;
        localparam int WATCHDOG_CYCLES = NUM_OPS * 20 + RESET_CYCLES;

        localparam logic [6:0] OPCODE_FMADD = 7'b1000011;

        logic      clk;
        logic      rstN;
        logic      fpuEnable;
        fpWord_t   instr;
        fpWord_t   rs1;
        fpWord_t   rs2;
        logic      valid;
        fpResult_t fpuOut;

        // Entry i has FCLASS bit i set
        fpWord_t corners [NUM_CORNERS] = '{
                32'hff80_0000, 32'hc020_0000, 32'h807f_ffff, 32'h8000_0000, 32'h0000_0000,
                32'h0000_0001, 32'h3f80_0000, 32'h7f80_0000, 32'h7f80_0001, 32'hffc1_2345
        };

        fpu uut (
                .clk_i       (clk),
                .rstN_i      (rstN),
                .fpuEnable_i (fpuEnable),
                .instr_i     (instr),
                .rs1_i       (rs1),
                .rs2_i       (rs2),
                .valid_o     (valid),
                .fpuOut_o    (fpuOut)
        );

        initial clk = 1'b0;
        always #(CLK_PERIOD / 2) clk = ~clk;

        function automatic fpWord_t buildInstr(input logic [4:0] funct5, input logic [1:0] fmt,
                                               input logic [4:0] rs2Field,
                                               input logic [2:0] funct3,
                                               input logic [6:0] opcode);
                return {funct5, fmt, rs2Field, 5'd1, funct3, 5'd3, opcode};
        endfunction

        function automatic fpResult_t boxed(input fpWord_t w);
                return {{(XLEN_OUT-FLEN){1'b1}}, w};
        endfunction

        function automatic logic nanWord(input fpWord_t w);
                return (w[30:23] == 8'hff) && (w[22:0] != 23'd0);
        endfunction

        function automatic logic zeroWord(input fpWord_t w);
                return w[30:0] == 31'd0;
        endfunction

        // Total order on non-NaN words, -0 below +0
        function automatic logic orderedBelow(input fpWord_t a, input fpWord_t b);
                if (a[31] != b[31])
                        return a[31];
                else if (!a[31])
                        return a[30:0] < b[30:0];
                else
                        return a[30:0] > b[30:0];
        endfunction

        function automatic logic lessThan(input fpWord_t a, input fpWord_t b);
                if (nanWord(a) || nanWord(b) || (zeroWord(a) && zeroWord(b)))
                        return 1'b0;
                return orderedBelow(a, b);
        endfunction

        function automatic logic equalTo(input fpWord_t a, input fpWord_t b);
                if (nanWord(a) || nanWord(b))
                        return 1'b0;
                return (a == b) || (zeroWord(a) && zeroWord(b));
        endfunction

        function automatic fpWord_t pickMinMax(input fpWord_t a, input fpWord_t b,
                                               input logic wantMax);
                if (nanWord(a) && nanWord(b))
                        return CANONICAL_NAN;
                if (nanWord(a))
                        return b;
                if (nanWord(b))
                        return a;
                return (orderedBelow(a, b) ^ wantMax) ? a : b;
        endfunction

        task automatic stopRun();
                $display("Test failed");
                $fatal(1, "stopping at the first error");
        endtask

        task automatic failRun(input string why);
                $display("%s (time %0t ns)", why, $time);
                stopRun();
        endtask

        task automatic checkResult(input fpResult_t got, input fpResult_t expected,
                                   input string msg);
                if (got !== expected) begin
                        $display("mismatch at %0t ns: %s, got %h expected %h",
                                 $time, msg, got, expected);
                        stopRun();
                end
        endtask

        task automatic checkClass(input fpResult_t got, input fpClass_t expected,
                                  input string msg);
                fpClass_t gotCls;
                gotCls = got[9:0];
                if (got[XLEN_OUT-1:10] !== '0 || gotCls !== expected) begin
                        $display("mismatch at %0t ns: %s, got %h expected class %b",
                                 $time, msg, got, expected);
                        stopRun();
                end
        endtask

        // One strobe, result sampled mid-cycle after the capturing edge
        task automatic runOp(input fpWord_t instrWord, input fpWord_t a, input fpWord_t b,
                             output fpResult_t res);
                @(posedge clk);
                fpuEnable <= 1'b1;
                instr     <= instrWord;
                rs1       <= a;
                rs2       <= b;
                @(posedge clk);
                fpuEnable <= 1'b0;
                @(negedge clk);
                if (valid !== 1'b1)
                        failRun("valid_o did not pulse one cycle after the enable");
                res = fpuOut;
        endtask

        task automatic testReset();
                fpResult_t res;
                fpWord_t   mvxw;
                mvxw = buildInstr(FUNCT5_CLASS_MVXW, 2'b00, 5'd0, 3'b000, OPCODE_OP_FP);
                repeat (3) begin
                        @(negedge clk);
                        if (valid !== 1'b0 || fpuOut !== '0)
                                failRun("outputs changed after reset without an enable");
                end
                runOp(buildInstr(FUNCT5_SGNJ, 2'b00, 5'd2, 3'b000, OPCODE_OP_FP),
                      32'h3f80_0000, 32'h8000_0000, res);
                checkResult(res, boxed(32'hbf80_0000), "first sgnj after reset");
                @(negedge clk);
                if (valid !== 1'b0)
                        failRun("valid_o stayed high for more than one cycle");
                // Two strobes in a row
                @(posedge clk);
                fpuEnable <= 1'b1;
                instr     <= mvxw;
                rs1       <= 32'h1234_5678;
                @(posedge clk);
                rs1       <= 32'h9abc_def0;
                @(negedge clk);
                if (valid !== 1'b1)
                        failRun("valid_o missing for the first back-to-back enable");
                checkResult(fpuOut, boxed(32'h1234_5678), "first back-to-back move");
                @(posedge clk);
                fpuEnable <= 1'b0;
                // New rs1 while idle must not reach the output
                rs1       <= 32'h0f0f_0f0f;
                @(negedge clk);
                if (valid !== 1'b1)
                        failRun("valid_o missing for the second back-to-back enable");
                checkResult(fpuOut, boxed(32'h9abc_def0), "second back-to-back move");
                @(negedge clk);
                if (valid !== 1'b0)
                        failRun("valid_o high after the enables stopped");
                checkResult(fpuOut, boxed(32'h9abc_def0), "output held while idle");
        endtask

        task automatic testSignInjection();
                fpResult_t res;
                fpWord_t   a;
                fpWord_t   b;
                repeat (RAND_PAIRS) begin
                        a = $urandom();
                        b = $urandom();
                        runOp(buildInstr(FUNCT5_SGNJ, 2'b00, 5'd2, 3'b000, OPCODE_OP_FP),
                              a, b, res);
                        checkResult(res, boxed({b[31], a[30:0]}), $sformatf("sgnj %h %h", a, b));
                        runOp(buildInstr(FUNCT5_SGNJ, 2'b00, 5'd2, 3'b001, OPCODE_OP_FP),
                              a, b, res);
                        checkResult(res, boxed({~b[31], a[30:0]}),
                                    $sformatf("sgnjn %h %h", a, b));
                        runOp(buildInstr(FUNCT5_SGNJ, 2'b00, 5'd2, 3'b010, OPCODE_OP_FP),
                              a, b, res);
                        checkResult(res, boxed({a[31] ^ b[31], a[30:0]}),
                                    $sformatf("sgnjx %h %h", a, b));
                end
        endtask

        task automatic compareOnce(input fpWord_t a, input fpWord_t b);
                fpResult_t res;
                runOp(buildInstr(FUNCT5_CMP, 2'b00, 5'd2, 3'b010, OPCODE_OP_FP), a, b, res);
                checkResult(res, fpResult_t'(equalTo(a, b)), $sformatf("feq %h %h", a, b));
                runOp(buildInstr(FUNCT5_CMP, 2'b00, 5'd2, 3'b001, OPCODE_OP_FP), a, b, res);
                checkResult(res, fpResult_t'(lessThan(a, b)), $sformatf("flt %h %h", a, b));
                runOp(buildInstr(FUNCT5_CMP, 2'b00, 5'd2, 3'b000, OPCODE_OP_FP), a, b, res);
                checkResult(res, fpResult_t'(lessThan(a, b) | equalTo(a, b)),
                            $sformatf("fle %h %h", a, b));
        endtask

        task automatic minMaxOnce(input fpWord_t a, input fpWord_t b);
                fpResult_t res;
                runOp(buildInstr(FUNCT5_MINMAX, 2'b00, 5'd2, 3'b000, OPCODE_OP_FP), a, b, res);
                checkResult(res, boxed(pickMinMax(a, b, 1'b0)), $sformatf("fmin %h %h", a, b));
                runOp(buildInstr(FUNCT5_MINMAX, 2'b00, 5'd2, 3'b001, OPCODE_OP_FP), a, b, res);
                checkResult(res, boxed(pickMinMax(a, b, 1'b1)), $sformatf("fmax %h %h", a, b));
        endtask

        // Corner pairs cover zeros, infinities, subnormals and both NaN kinds
        task automatic testCompare();
                fpWord_t a;
                for (int i = 0; i < NUM_CORNERS; i++)
                        for (int j = 0; j < NUM_CORNERS; j++)
                                compareOnce(corners[i], corners[j]);
                repeat (RAND_PAIRS) begin
                        a = $urandom();
                        compareOnce(a, ($urandom() % 4 == 0) ? a : $urandom());
                end
        endtask

        task automatic testMinMax();
                for (int i = 0; i < NUM_CORNERS; i++)
                        for (int j = 0; j < NUM_CORNERS; j++)
                                minMaxOnce(corners[i], corners[j]);
                repeat (RAND_PAIRS)
                        minMaxOnce($urandom(), $urandom());
        endtask

        task automatic testClassify();
                fpResult_t res;
                fpClass_t  expCls;
                for (int i = 0; i < NUM_CORNERS; i++) begin
                        expCls    = '0;
                        expCls[i] = 1'b1;
                        runOp(buildInstr(FUNCT5_CLASS_MVXW, 2'b00, 5'd0, 3'b001, OPCODE_OP_FP),
                              corners[i], 32'h0, res);
                        checkClass(res, expCls, $sformatf("fclass %h", corners[i]));
                end
        endtask

        task automatic testMoves();
                fpResult_t res;
                runOp(buildInstr(FUNCT5_CLASS_MVXW, 2'b00, 5'd0, 3'b000, OPCODE_OP_FP),
                      32'hdead_beef, 32'h0, res);
                checkResult(res, boxed(32'hdead_beef), "fmv.x.w");
                runOp(buildInstr(FUNCT5_MVWX, 2'b00, 5'd0, 3'b000, OPCODE_OP_FP),
                      32'h0bad_f00d, 32'h0, res);
                checkResult(res, boxed(32'h0bad_f00d), "fmv.w.x");
                // Unsupported words must clear a nonzero previous result
                runOp(buildInstr(FUNCT5_SGNJ, 2'b01, 5'd2, 3'b000, OPCODE_OP_FP),
                      32'h3f80_0000, 32'h4000_0000, res);
                checkResult(res, '0, "double-format sgnj");
                runOp(buildInstr(FUNCT5_SGNJ, 2'b00, 5'd2, 3'b000, OPCODE_FMADD),
                      32'h3f80_0000, 32'h4000_0000, res);
                checkResult(res, '0, "fmadd opcode");
                runOp(buildInstr(FUNCT5_SGNJ, 2'b00, 5'd2, 3'b111, OPCODE_OP_FP),
                      32'h3f80_0000, 32'h4000_0000, res);
                checkResult(res, '0, "sgnj with bad funct3");
        endtask

        initial begin
                void'($urandom(32'he065_035a));
                rstN      <= 1'b0;
                fpuEnable <= 1'b0;
                instr     <= '0;
                rs1       <= '0;
                rs2       <= '0;
                repeat (RESET_CYCLES - 1) @(posedge clk);
                @(negedge clk);
                if (valid !== 1'b0 || fpuOut !== '0)
                        failRun("outputs not cleared while reset is held");
                @(posedge clk);
                rstN <= 1'b1;

                testReset();
                testSignInjection();
                testCompare();
                testMinMax();
                testClassify();
                testMoves();

                $display("Test passed");
                $finish;
        end

        // Run limit scaled to the number of issued operations
        initial begin
                #(WATCHDOG_CYCLES * CLK_PERIOD);
                failRun("watchdog expired before the tests finished");
        end

endmodule

`default_nettype wire
